// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int TAG_W = 8;

    typedef enum logic {
        kind_load  = 1'b0,
        kind_store = 1'b1
    } mem_kind_e;

    // Encoded as funct3[1:0]
    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        cover_none    = 2'd0,
        cover_partial = 2'd1,
        cover_full    = 2'd2
    } cover_e;

    typedef struct packed {
        mem_kind_e        kind;
        logic [2:0]       funct3;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [TAG_W-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        mem_kind_e        kind;
        mem_width_e       width;
        logic             is_unsigned;
        logic [29:0]      waddr;
        logic [3:0]       mask;
        logic [31:0]      data;  // Already in its byte lanes
        logic [TAG_W-1:0] tag;
        logic             fault;
    } mem_op_t;

    typedef struct packed {
        mem_kind_e        kind;
        logic [TAG_W-1:0] tag;
        logic             fault;
        cover_e           coverage;
        logic [31:0]      data;
    } lsu_resp_t;

    typedef struct packed {
        logic [29:0] waddr;
        logic [3:0]  mask;
        logic [31:0] data;
    } mem_write_t;

endpackage

`default_nettype wire

// ==== hw/mem_op_decode.sv ====
`default_nettype none

module mem_op_decode (
    input  wire                logic clk,
    input  wire                logic rst_n,
    input  wire                logic flush,
    input  wire                logic req_valid,
    output logic               req_ready,
    input  lsu_pkg::mem_req_t  req,
    output logic               op_valid,
    input  wire                logic op_ready,
    output lsu_pkg::mem_op_t   op
);

    lsu_pkg::mem_op_t dec;
    logic [3:0]       base_mask;
    logic             legal;
    logic             misaligned;
    logic             req_fire;

    always_comb begin
        dec.kind        = req.kind;
        dec.is_unsigned = req.funct3[2];
        dec.waddr       = req.addr[31:2];
        dec.tag         = req.tag;
        dec.data        = req.data << {req.addr[1:0], 3'b000};  // Move into byte lanes

        case (req.funct3[1:0])
            2'd0: begin
                dec.width  = lsu_pkg::width_byte;
                base_mask  = 4'b0001;
                misaligned = 1'b0;
            end
            2'd1: begin
                dec.width  = lsu_pkg::width_half;
                base_mask  = 4'b0011;
                misaligned = req.addr[0];
            end
            2'd2: begin
                dec.width  = lsu_pkg::width_word;
                base_mask  = 4'b1111;
                misaligned = |req.addr[1:0];
            end
            default: begin
                dec.width  = lsu_pkg::width_word;  // Illegal code, faults below
                base_mask  = 4'b0000;
                misaligned = 1'b0;
            end
        endcase

        // Loads take 0,1,2,4,5 and stores only 0,1,2
        legal = (req.funct3[1:0] != 2'd3) &&
                (!req.funct3[2] ||
                 (req.kind == lsu_pkg::kind_load && req.funct3[1:0] != 2'd2));

        dec.fault = !legal || misaligned;
        dec.mask  = dec.fault ? 4'b0000 : base_mask << req.addr[1:0];
    end

    assign req_ready = !op_valid || op_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            op_valid <= 1'b0;
        end else if (req_fire) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            op <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== hw/store_buffer.sv ====
`default_nettype none

module store_buffer #(
    parameter int DEPTH = 8
) (
    input  wire                logic clk,
    input  wire                logic rst_n,
    input  wire                logic flush,
    input  wire                logic op_valid,
    output logic               op_ready,
    input  lsu_pkg::mem_op_t   op,
    input  wire                logic commit_valid,
    output logic               commit_ready,
    input  wire                logic [lsu_pkg::TAG_W-1:0] commit_tag,
    output logic               mem_valid,
    input  wire                logic mem_ready,
    output lsu_pkg::mem_write_t mem_wr,
    output logic               lk_valid,
    input  wire                logic lk_ready,
    output lsu_pkg::mem_op_t   lk_op,
    output logic [31:0]        lk_data,
    output logic [3:0]         lk_mask,
    output logic               lk_hit
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0]          ent_valid;
    logic [29:0]               ent_waddr [DEPTH];
    logic [3:0]                ent_mask  [DEPTH];
    logic [31:0]               ent_data  [DEPTH];
    logic [lsu_pkg::TAG_W-1:0] ent_tag   [DEPTH];

    logic [DEPTH-1:0] ent_live;
    logic             commit_fire;
    logic             commit_hit;
    logic [IDX_W-1:0] commit_idx;
    logic             is_store;
    logic             is_load;
    logic             st_hit;
    logic             ld_hit;
    logic             free_any;
    logic [IDX_W-1:0] st_idx;
    logic [IDX_W-1:0] ld_idx;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             stall_full;
    logic             op_fire;

    assign commit_ready = !mem_valid || mem_ready;
    assign commit_fire  = commit_valid && commit_ready;

    // Tag of a store merged away is simply not found
    always_comb begin
        commit_hit = 1'b0;
        commit_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ent_valid[i] && ent_tag[i] == commit_tag) begin
                commit_hit = 1'b1;
                commit_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        ent_live = ent_valid;  // Entries left after this cycle's commit
        if (commit_fire && commit_hit) begin
            ent_live[commit_idx] = 1'b0;
        end
    end

    // Stores see the post-commit view, loads still see a word leaving for memory
    always_comb begin
        st_hit   = 1'b0;
        st_idx   = '0;
        ld_hit   = 1'b0;
        ld_idx   = '0;
        free_any = 1'b0;
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ent_live[i] && ent_waddr[i] == op.waddr) begin
                st_hit = 1'b1;
                st_idx = IDX_W'(i);
            end
            if (ent_valid[i] && ent_waddr[i] == op.waddr) begin
                ld_hit = 1'b1;
                ld_idx = IDX_W'(i);
            end
            if (!ent_live[i]) begin
                free_any = 1'b1;
                free_idx = IDX_W'(i);  // Lowest free wins
            end
        end
    end

    assign is_store   = op.kind == lsu_pkg::kind_store && !op.fault;
    assign is_load    = op.kind == lsu_pkg::kind_load && !op.fault;
    assign stall_full = op_valid && is_store && !st_hit && !free_any;
    assign op_ready   = (!lk_valid || lk_ready) && !stall_full;
    assign op_fire    = op_valid && op_ready;
    assign wr_idx     = st_hit ? st_idx : free_idx;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ent_valid <= '0;
        end else begin
            ent_valid <= ent_live;
            if (op_fire && is_store) begin
                ent_valid[wr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire && is_store) begin
            ent_waddr[wr_idx] <= op.waddr;
            ent_tag[wr_idx]   <= op.tag;  // Younger tag takes over on merge
            ent_mask[wr_idx]  <= st_hit ? (ent_mask[wr_idx] | op.mask) : op.mask;
            for (int b = 0; b < 4; b++) begin
                if (op.mask[b]) begin
                    ent_data[wr_idx][8*b +: 8] <= op.data[8*b +: 8];
                end
            end
        end
    end

    // Drain register survives flush, its store is committed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else if (commit_fire && commit_hit) begin
            mem_valid <= 1'b1;
        end else if (mem_ready) begin
            mem_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_fire && commit_hit) begin
            mem_wr.waddr <= ent_waddr[commit_idx];
            mem_wr.mask  <= ent_mask[commit_idx];
            mem_wr.data  <= ent_data[commit_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            lk_valid <= 1'b0;
        end else if (op_fire) begin
            lk_valid <= 1'b1;
        end else if (lk_ready) begin
            lk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            lk_op   <= op;
            lk_hit  <= is_load && ld_hit;
            lk_data <= (is_load && ld_hit) ? ent_data[ld_idx] : 32'd0;
            lk_mask <= (is_load && ld_hit) ? ent_mask[ld_idx] : 4'd0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/load_result.sv ====
`default_nettype none

module load_result (
    input  wire                logic clk,
    input  wire                logic rst_n,
    input  wire                logic flush,
    input  wire                logic lk_valid,
    output logic               lk_ready,
    input  lsu_pkg::mem_op_t   lk_op,
    input  wire                logic [31:0] lk_data,
    input  wire                logic [3:0] lk_mask,
    input  wire                logic lk_hit,
    output logic               resp_valid,
    input  wire                logic resp_ready,
    output lsu_pkg::lsu_resp_t resp
);

    logic [1:0]         lane;
    logic [31:0]        shifted;
    logic [31:0]        ext_data;
    lsu_pkg::cover_e    cov;
    lsu_pkg::lsu_resp_t nxt;

    always_comb begin
        // Lowest set mask bit gives the byte offset
        if (lk_op.mask[0]) begin
            lane = 2'd0;
        end else if (lk_op.mask[1]) begin
            lane = 2'd1;
        end else if (lk_op.mask[2]) begin
            lane = 2'd2;
        end else begin
            lane = 2'd3;
        end
        shifted = lk_data >> {lane, 3'b000};

        case (lk_op.width)
            lsu_pkg::width_byte:
                ext_data = {{24{shifted[7] & ~lk_op.is_unsigned}}, shifted[7:0]};
            lsu_pkg::width_half:
                ext_data = {{16{shifted[15] & ~lk_op.is_unsigned}}, shifted[15:0]};
            default:
                ext_data = shifted;
        endcase

        if (lk_op.kind != lsu_pkg::kind_load || lk_op.fault || !lk_hit) begin
            cov = lsu_pkg::cover_none;
        end else if ((lk_op.mask & ~lk_mask) == 4'd0) begin
            cov = lsu_pkg::cover_full;
        end else if ((lk_op.mask & lk_mask) != 4'd0) begin
            cov = lsu_pkg::cover_partial;  // Core has to go to memory
        end else begin
            cov = lsu_pkg::cover_none;
        end

        nxt.kind     = lk_op.kind;
        nxt.tag      = lk_op.tag;
        nxt.fault    = lk_op.fault;
        nxt.coverage = cov;
        nxt.data     = (cov == lsu_pkg::cover_full) ? ext_data : 32'd0;
    end

    assign lk_ready = !resp_valid || resp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            resp_valid <= 1'b0;
        end else if (lk_valid && lk_ready) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lk_valid && lk_ready) begin
            resp <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/store_buffer_top.sv ====
`default_nettype none

module store_buffer_top #(
    parameter int DEPTH = 8  // Power of two
) (
    input  wire                 logic clk,
    input  wire                 logic rst_n,
    input  wire                 logic flush,
    input  wire                 logic req_valid,
    output logic                req_ready,
    input  lsu_pkg::mem_req_t   req,
    output logic                resp_valid,
    input  wire                 logic resp_ready,
    output lsu_pkg::lsu_resp_t  resp,
    input  wire                 logic commit_valid,
    output logic                commit_ready,
    input  wire                 logic [lsu_pkg::TAG_W-1:0] commit_tag,
    output logic                mem_valid,
    input  wire                 logic mem_ready,
    output lsu_pkg::mem_write_t mem_wr
);

    logic             op_valid;
    logic             op_ready;
    lsu_pkg::mem_op_t op;
    logic             lk_valid;
    logic             lk_ready;
    lsu_pkg::mem_op_t lk_op;
    logic [31:0]      lk_data;
    logic [3:0]       lk_mask;
    logic             lk_hit;

    mem_op_decode mem_op_decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op        (op)
    );

    store_buffer #(
        .DEPTH (DEPTH)
    ) store_buffer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .op_valid     (op_valid),
        .op_ready     (op_ready),
        .op           (op),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_tag   (commit_tag),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_wr       (mem_wr),
        .lk_valid     (lk_valid),
        .lk_ready     (lk_ready),
        .lk_op        (lk_op),
        .lk_data      (lk_data),
        .lk_mask      (lk_mask),
        .lk_hit       (lk_hit)
    );

    load_result load_result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .lk_valid   (lk_valid),
        .lk_ready   (lk_ready),
        .lk_op      (lk_op),
        .lk_data    (lk_data),
        .lk_mask    (lk_mask),
        .lk_hit     (lk_hit),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// ==== test/store_buffer_properties.sv ====
`default_nettype none

module store_buffer_properties (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                req_valid,
    input wire logic                req_ready,
    input lsu_pkg::mem_req_t        req,
    input wire logic                resp_valid,
    input wire logic                resp_ready,
    input lsu_pkg::lsu_resp_t       resp,
    input wire logic                mem_valid,
    input wire logic                mem_ready,
    input lsu_pkg::mem_write_t      mem_wr
);
    timeunit 1ns;
    timeprecision 100ps;

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request dropped or changed before ready");

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response dropped or changed before ready");

    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_wr))
        else $error("drain write dropped or changed before ready");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !resp_valid && !mem_valid)
        else $error("valid high out of reset");

endmodule

bind store_buffer_top store_buffer_properties store_buffer_properties_i (.*);

`default_nettype wire

// ==== test/tb_store_buffer_top.sv ====
`default_nettype none

module tb_store_buffer_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TEST_CYCLES = 1500;  // Rough sum over all tests
    localparam int SLOTS       = 16;

    logic clk = 1'b0;
    logic rst_n, flush, req_valid, resp_ready, commit_valid, mem_ready;
    logic req_ready, resp_valid, commit_ready, mem_valid;
    logic [lsu_pkg::TAG_W-1:0] commit_tag;
    lsu_pkg::mem_req_t   req;
    lsu_pkg::lsu_resp_t  resp;
    lsu_pkg::mem_write_t mem_wr;

    logic [15:0] lfsr = 16'd74;
    logic        rand_ready = 1'b0;
    logic        ready_bit = 1'b1;
    logic [7:0]  next_tag = 8'd1;
    logic [7:0]  last_tag;
    int          value_errors = 0;
    int          other_errors = 0;
    lsu_pkg::lsu_resp_t  exp_resp[$];
    lsu_pkg::mem_write_t exp_wr[$];

    // Reference buffer with one slot per word
    logic        m_valid [SLOTS];
    logic [29:0] m_waddr [SLOTS];
    logic [3:0]  m_mask  [SLOTS];
    logic [31:0] m_data  [SLOTS];
    logic [7:0]  m_tag   [SLOTS];

    store_buffer_top #(.DEPTH(8)) store_buffer_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic lfsr_step();
        logic b;
        b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], b};
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic int find_word(logic [29:0] w);
        for (int i = 0; i < SLOTS; i++) if (m_valid[i] && m_waddr[i] == w) return i;
        return -1;
    endfunction

    // Builds the expected response and applies store effects to the model
    function automatic lsu_pkg::lsu_resp_t apply_request(lsu_pkg::mem_req_t r);
        lsu_pkg::lsu_resp_t e;
        logic [1:0]  off;
        logic [3:0]  m;
        logic        bad;
        int          s;
        logic [31:0] v;
        off = r.addr[1:0];
        case (r.funct3[1:0])
            2'd0: begin
                m   = 4'b0001;
                bad = 1'b0;
            end
            2'd1: begin
                m   = 4'b0011;
                bad = off[0];
            end
            2'd2: begin
                m   = 4'b1111;
                bad = off != 2'd0;
            end
            default: begin
                m   = 4'b0000;
                bad = 1'b1;
            end
        endcase
        if (r.funct3[2] && (r.kind == lsu_pkg::kind_store || r.funct3[1:0] == 2'd2)) begin
            bad = 1'b1;
        end
        m = 4'(m << off);
        e.kind = r.kind;
        e.tag = r.tag;
        e.fault = bad;
        e.coverage = lsu_pkg::cover_none;
        e.data = 32'd0;
        if (bad) return e;
        s = find_word(r.addr[31:2]);
        if (r.kind == lsu_pkg::kind_store) begin
            if (s < 0) begin
                for (int i = SLOTS - 1; i >= 0; i--) if (!m_valid[i]) s = i;
                m_valid[s] = 1'b1;
                m_waddr[s] = r.addr[31:2];
                m_mask[s]  = 4'b0000;
            end
            v = r.data << {off, 3'b000};
            for (int b = 0; b < 4; b++) if (m[b]) m_data[s][8*b +: 8] = v[8*b +: 8];
            m_mask[s] = m_mask[s] | m;
            m_tag[s]  = r.tag;
        end else if (s >= 0) begin
            if ((m & ~m_mask[s]) == 4'd0) begin
                e.coverage = lsu_pkg::cover_full;
                v = m_data[s] >> {off, 3'b000};
                if (r.funct3[1:0] == 2'd0) e.data = {{24{v[7] & ~r.funct3[2]}}, v[7:0]};
                else if (r.funct3[1:0] == 2'd1) e.data = {{16{v[15] & ~r.funct3[2]}}, v[15:0]};
                else e.data = v;
            end else if ((m & m_mask[s]) != 4'd0) begin
                e.coverage = lsu_pkg::cover_partial;
            end
        end
        return e;
    endfunction

    task automatic value_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("CHECK FAILED %s got %h expected %h", name, got, want);
        value_errors++;
    endtask

    task automatic check_resp(lsu_pkg::lsu_resp_t got, lsu_pkg::lsu_resp_t want);
        if (got.kind !== want.kind) value_mismatch("resp.kind", 32'(got.kind), 32'(want.kind));
        if (got.tag !== want.tag) value_mismatch("resp.tag", 32'(got.tag), 32'(want.tag));
        if (got.fault !== want.fault)
            value_mismatch("resp.fault", 32'(got.fault), 32'(want.fault));
        if (got.coverage !== want.coverage)
            value_mismatch("resp.coverage", 32'(got.coverage), 32'(want.coverage));
        if (got.data !== want.data) value_mismatch("resp.data", got.data, want.data);
    endtask

    task automatic check_mem_write(lsu_pkg::mem_write_t got, lsu_pkg::mem_write_t want);
        if (got.waddr !== want.waddr)
            value_mismatch("mem_wr.waddr", 32'(got.waddr), 32'(want.waddr));
        if (got.mask !== want.mask) value_mismatch("mem_wr.mask", 32'(got.mask), 32'(want.mask));
        if (got.data !== want.data) value_mismatch("mem_wr.data", got.data, want.data);
    endtask

    always @(posedge clk) begin
        if (rst_n && resp_valid && resp_ready) begin
            if (exp_resp.size() == 0) begin
                $display("Response arrived with none outstanding, tag %h", resp.tag);
                other_errors++;
            end else begin
                check_resp(resp, exp_resp.pop_front());
            end
        end
        if (rst_n && mem_valid && mem_ready) begin
            if (exp_wr.size() == 0) begin
                $display("Memory write arrived that no commit should produce");
                other_errors++;
            end else begin
                check_mem_write(mem_wr, exp_wr.pop_front());
            end
        end
    end

    // Next ready value drawn half a cycle ahead of its use
    always @(negedge clk) begin
        ready_bit = rand_ready ? lfsr_step() : 1'b1;  // Random stall when enabled
    end

    always @(posedge clk) begin
        #1 resp_ready = ready_bit;
    end

    task automatic send(lsu_pkg::mem_kind_e kind, logic [2:0] f3, logic [31:0] addr,
                        logic [31:0] data);
        lsu_pkg::mem_req_t r;
        r.kind = kind;
        r.funct3 = f3;
        r.addr = addr;
        r.data = data;
        r.tag = next_tag;
        last_tag = next_tag;
        next_tag++;
        exp_resp.push_back(apply_request(r));
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req = r;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1 req_valid = 1'b0;
    endtask

    task automatic commit(logic [7:0] tag);
        lsu_pkg::mem_write_t w;
        for (int i = 0; i < SLOTS; i++) begin
            if (m_valid[i] && m_tag[i] == tag) begin
                w.waddr = m_waddr[i];
                w.mask = m_mask[i];
                w.data = m_data[i];
                exp_wr.push_back(w);
                m_valid[i] = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        commit_valid = 1'b1;
        commit_tag = tag;
        do @(negedge clk); while (!commit_ready);
        @(posedge clk);
        #1 commit_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_resp.size() != 0 || exp_wr.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        #1 flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        for (int i = 0; i < SLOTS; i++) m_valid[i] = 1'b0;
    endtask

    task automatic forwarding_extension();
        send(lsu_pkg::kind_store, 3'd2, 32'h1000, rand_bits(32));
        for (int o = 0; o < 4; o++) begin
            send(lsu_pkg::kind_load, 3'd0, 32'h1000 + o, 32'd0);  // LB
            send(lsu_pkg::kind_load, 3'd4, 32'h1000 + o, 32'd0);  // LBU
        end
        for (int o = 0; o < 4; o += 2) begin
            send(lsu_pkg::kind_load, 3'd1, 32'h1000 + o, 32'd0);
            send(lsu_pkg::kind_load, 3'd5, 32'h1000 + o, 32'd0);
        end
        send(lsu_pkg::kind_load, 3'd2, 32'h1000, 32'd0);
        wait_idle();
    endtask

    task automatic merge_and_commit();
        logic [7:0] older;
        send(lsu_pkg::kind_store, 3'd2, 32'h2000, rand_bits(32));
        older = last_tag;
        send(lsu_pkg::kind_store, 3'd0, 32'h2001, rand_bits(32));
        send(lsu_pkg::kind_load, 3'd2, 32'h2000, 32'd0);  // Full coverage of merged bytes
        send(lsu_pkg::kind_store, 3'd0, 32'h2006, rand_bits(32));
        send(lsu_pkg::kind_load, 3'd2, 32'h2004, 32'd0);  // Partial
        send(lsu_pkg::kind_load, 3'd2, 32'h2008, 32'd0);  // None
        wait_idle();
        commit(older);  // Tag merged away so no write
        wait_idle();
        #1 mem_ready = 1'b0;
        commit(older + 8'd1);
        repeat (5) begin
            @(negedge clk);
            if (!mem_valid) begin
                $display("Drain write not held while memory stalls");
                other_errors++;
            end
        end
        @(posedge clk);
        #1 mem_ready = 1'b1;
        wait_idle();
    endtask

    task automatic fault_responses();
        send(lsu_pkg::kind_load, 3'd1, 32'h3001, 32'd0);
        send(lsu_pkg::kind_store, 3'd2, 32'h3002, rand_bits(32));
        send(lsu_pkg::kind_load, 3'd3, 32'h3000, 32'd0);
        send(lsu_pkg::kind_store, 3'd4, 32'h3000, rand_bits(32));
        send(lsu_pkg::kind_load, 3'd2, 32'h3000, 32'd0);
        wait_idle();
    endtask

    task automatic capacity_backpressure();
        logic [7:0] first;
        pulse_flush();
        for (int i = 0; i < 9; i++) begin
            send(lsu_pkg::kind_store, 3'd2, 32'h4000 + 32'(4 * i), rand_bits(32));
            if (i == 0) first = last_tag;
        end
        repeat (4) @(negedge clk);
        if (req_ready) begin
            $display("Ninth store into a full buffer did not stall requests");
            other_errors++;
        end
        commit(first);
        wait_idle();
        rand_ready = 1'b1;
        for (int i = 0; i < 30; i++) begin
            if (lfsr_step())
                send(lsu_pkg::kind_store, 3'd2, 32'h4004 + (rand_bits(3) << 2), rand_bits(32));
            else
                send(lsu_pkg::kind_load, 3'd4, 32'h4004 + rand_bits(5), 32'd0);
        end
        wait_idle();
        rand_ready = 1'b0;
    endtask

    task automatic flush_keeps_drain();
        int s;
        s = find_word(30'h1001);
        #1 mem_ready = 1'b0;
        commit(m_tag[s]);
        pulse_flush();
        send(lsu_pkg::kind_load, 3'd2, 32'h4008, 32'd0);
        send(lsu_pkg::kind_load, 3'd2, 32'h4004, 32'd0);
        while (exp_resp.size() != 0) @(posedge clk);
        #1 mem_ready = 1'b1;
        wait_idle();
    endtask

    initial begin
        #(TEST_CYCLES * 4 * 2);
        $display("Watchdog expired with %0d responses and %0d writes outstanding",
                 exp_resp.size(), exp_wr.size());
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        for (int i = 0; i < SLOTS; i++) m_valid[i] = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b1;
        commit_valid = 1'b0;
        commit_tag = '0;
        mem_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        forwarding_extension();
        merge_and_commit();
        fault_responses();
        capacity_backpressure();
        flush_keeps_drain();
        $display("Errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/lsu_pkg.sv
hw/mem_op_decode.sv
hw/store_buffer.sv
hw/load_result.sv
hw/store_buffer_top.sv
test/store_buffer_properties.sv
test/tb_store_buffer_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the store buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_store_buffer_top \
    -o sim_store_buffer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_store_buffer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
